//--- logic/id_pkg.sv
`default_nettype none

package id_pkg;

	////////////////////////////////////////////////////////////////////////////
	// widths.
	localparam int xlen = 32;
	localparam int reg_addr_w = 5;
	localparam int alu_op_w = 12;
	localparam int br_kind_w = 4;

	localparam logic [reg_addr_w-1:0] reg_ra = 5'd1; // link register.

	// one-hot alu operation bits.
	localparam int alu_add = 0;
	localparam int alu_sub = 1;
	localparam int alu_slt = 2;
	localparam int alu_sltu = 3;
	localparam int alu_and = 4;
	localparam int alu_nor = 5;
	localparam int alu_or = 6;
	localparam int alu_xor = 7;
	localparam int alu_sll = 8;
	localparam int alu_srl = 9;
	localparam int alu_sra = 10;
	localparam int alu_lui = 11;

	// branch kinds.
	localparam logic [br_kind_w-1:0] br_none = 4'd0;
	localparam logic [br_kind_w-1:0] br_eq = 4'd1;
	localparam logic [br_kind_w-1:0] br_ne = 4'd2;
	localparam logic [br_kind_w-1:0] br_lt = 4'd3;
	localparam logic [br_kind_w-1:0] br_ge = 4'd4;
	localparam logic [br_kind_w-1:0] br_ltu = 4'd5;
	localparam logic [br_kind_w-1:0] br_geu = 4'd6;
	localparam logic [br_kind_w-1:0] br_always = 4'd7; // b and bl.
	localparam logic [br_kind_w-1:0] br_jirl = 4'd8;

	////////////////////////////////////////////////////////////////////////////
	// opcodes, 3r format (inst[31:15]).
	localparam logic [16:0] op3r_add_w = 17'h00020;
	localparam logic [16:0] op3r_sub_w = 17'h00022;
	localparam logic [16:0] op3r_slt = 17'h00024;
	localparam logic [16:0] op3r_sltu = 17'h00025;
	localparam logic [16:0] op3r_nor = 17'h00028;
	localparam logic [16:0] op3r_and = 17'h00029;
	localparam logic [16:0] op3r_or = 17'h0002a;
	localparam logic [16:0] op3r_xor = 17'h0002b;
	localparam logic [16:0] op3r_sll_w = 17'h0002e;
	localparam logic [16:0] op3r_srl_w = 17'h0002f;
	localparam logic [16:0] op3r_sra_w = 17'h00030;
	localparam logic [16:0] op3r_slli_w = 17'h00081; // ui5 sits in the rk field.
	localparam logic [16:0] op3r_srli_w = 17'h00089;
	localparam logic [16:0] op3r_srai_w = 17'h00091;

	// 2ri12 format (inst[31:22]).
	localparam logic [9:0] op12_slti = 10'h008;
	localparam logic [9:0] op12_sltui = 10'h009;
	localparam logic [9:0] op12_addi_w = 10'h00a;
	localparam logic [9:0] op12_andi = 10'h00d;
	localparam logic [9:0] op12_ori = 10'h00e;
	localparam logic [9:0] op12_xori = 10'h00f;
	localparam logic [9:0] op12_ld_w = 10'h0a2;
	localparam logic [9:0] op12_st_w = 10'h0a6;

	// 1ri20 format (inst[31:25]).
	localparam logic [6:0] op20_lu12i_w = 7'h0a;
	localparam logic [6:0] op20_pcaddu12i = 7'h0e;

	// branch formats (inst[31:26]).
	localparam logic [5:0] op16_jirl = 6'h13;
	localparam logic [5:0] op26_b = 6'h14;
	localparam logic [5:0] op26_bl = 6'h15;
	localparam logic [5:0] op16_beq = 6'h16;
	localparam logic [5:0] op16_bne = 6'h17;
	localparam logic [5:0] op16_blt = 6'h18;
	localparam logic [5:0] op16_bge = 6'h19;
	localparam logic [5:0] op16_bltu = 6'h1a;
	localparam logic [5:0] op16_bgeu = 6'h1b;

	// one instruction word seen as 3r or as 2ri12.
	typedef union packed {
		struct packed {
			logic [16:0] opcode;
			logic [4:0] rk;
			logic [4:0] rj;
			logic [4:0] rd;
		} fmt_3r;
		struct packed {
			logic [9:0] opcode;
			logic [11:0] imm12;
			logic [4:0] rj;
			logic [4:0] rd;
		} fmt_2ri12;
	} inst_u;

endpackage

`default_nettype wire

//--- logic/inst_decoder.sv
`default_nettype none

module inst_decoder (
	input wire id_pkg::inst_u inst,
	output logic [id_pkg::alu_op_w-1:0] alu_op,
	output logic src1_is_pc,
	output logic src2_is_imm,
	output logic res_from_mem,
	output logic gr_we,
	output logic mem_we,
	output logic [id_pkg::reg_addr_w-1:0] dest,
	output logic [id_pkg::xlen-1:0] imm,
	output logic [id_pkg::reg_addr_w-1:0] raddr1,
	output logic [id_pkg::reg_addr_w-1:0] raddr2,
	output logic [id_pkg::br_kind_w-1:0] br_kind,
	output logic [id_pkg::xlen-1:0] br_offs
);

	logic [16:0] op17;
	logic [9:0] op10;
	logic [6:0] op7;
	logic [5:0] op6;
	logic [4:0] rd, rj, rk;
	logic [11:0] i12;
	logic [15:0] i16;
	logic [19:0] i20;
	logic [25:0] i26;
	logic inst_add_w, inst_sub_w, inst_slt, inst_sltu, inst_nor, inst_and;
	logic inst_or, inst_xor, inst_sll_w, inst_srl_w, inst_sra_w;
	logic inst_slli_w, inst_srli_w, inst_srai_w, inst_addi_w, inst_slti, inst_sltui;
	logic inst_andi, inst_ori, inst_xori, inst_lu12i_w, inst_pcaddu12i;
	logic inst_ld_w, inst_st_w;
	logic inst_jirl, inst_b, inst_bl, inst_beq, inst_bne;
	logic inst_blt, inst_bge, inst_bltu, inst_bgeu;
	logic need_ui12, need_si20, need_si26, cond_br;

	////////////////////////////////////////////////////////////////////////////
	// fields.
	assign op17 = inst.fmt_3r.opcode;
	assign op10 = inst.fmt_2ri12.opcode;
	assign op7 = op10[9:3];
	assign op6 = op10[9:4];
	assign rd = inst.fmt_3r.rd;
	assign rj = inst.fmt_3r.rj;
	assign rk = inst.fmt_3r.rk;
	assign i12 = inst.fmt_2ri12.imm12;
	assign i16 = {op10[3:0], i12}; // inst[25:10].
	assign i20 = {op10[2:0], i12, inst.fmt_2ri12.rj};
	assign i26 = {rj, rd, i16}; // high half sits in the low bits.

	assign inst_add_w = op17 == id_pkg::op3r_add_w;
	assign inst_sub_w = op17 == id_pkg::op3r_sub_w;
	assign inst_slt = op17 == id_pkg::op3r_slt;
	assign inst_sltu = op17 == id_pkg::op3r_sltu;
	assign inst_nor = op17 == id_pkg::op3r_nor;
	assign inst_and = op17 == id_pkg::op3r_and;
	assign inst_or = op17 == id_pkg::op3r_or;
	assign inst_xor = op17 == id_pkg::op3r_xor;
	assign inst_sll_w = op17 == id_pkg::op3r_sll_w;
	assign inst_srl_w = op17 == id_pkg::op3r_srl_w;
	assign inst_sra_w = op17 == id_pkg::op3r_sra_w;
	assign inst_slli_w = op17 == id_pkg::op3r_slli_w;
	assign inst_srli_w = op17 == id_pkg::op3r_srli_w;
	assign inst_srai_w = op17 == id_pkg::op3r_srai_w;
	assign inst_addi_w = op10 == id_pkg::op12_addi_w;
	assign inst_slti = op10 == id_pkg::op12_slti;
	assign inst_sltui = op10 == id_pkg::op12_sltui;
	assign inst_andi = op10 == id_pkg::op12_andi;
	assign inst_ori = op10 == id_pkg::op12_ori;
	assign inst_xori = op10 == id_pkg::op12_xori;
	assign inst_ld_w = op10 == id_pkg::op12_ld_w;
	assign inst_st_w = op10 == id_pkg::op12_st_w;
	assign inst_lu12i_w = op7 == id_pkg::op20_lu12i_w;
	assign inst_pcaddu12i = op7 == id_pkg::op20_pcaddu12i;
	assign inst_jirl = op6 == id_pkg::op16_jirl;
	assign inst_b = op6 == id_pkg::op26_b;
	assign inst_bl = op6 == id_pkg::op26_bl;
	assign inst_beq = op6 == id_pkg::op16_beq;
	assign inst_bne = op6 == id_pkg::op16_bne;
	assign inst_blt = op6 == id_pkg::op16_blt;
	assign inst_bge = op6 == id_pkg::op16_bge;
	assign inst_bltu = op6 == id_pkg::op16_bltu;
	assign inst_bgeu = op6 == id_pkg::op16_bgeu;

	////////////////////////////////////////////////////////////////////////////
	// controls.
	assign alu_op[id_pkg::alu_add] = inst_add_w | inst_addi_w | inst_ld_w | inst_st_w
		| inst_jirl | inst_bl | inst_pcaddu12i;
	assign alu_op[id_pkg::alu_sub] = inst_sub_w;
	assign alu_op[id_pkg::alu_slt] = inst_slt | inst_slti;
	assign alu_op[id_pkg::alu_sltu] = inst_sltu | inst_sltui;
	assign alu_op[id_pkg::alu_and] = inst_and | inst_andi;
	assign alu_op[id_pkg::alu_nor] = inst_nor;
	assign alu_op[id_pkg::alu_or] = inst_or | inst_ori;
	assign alu_op[id_pkg::alu_xor] = inst_xor | inst_xori;
	assign alu_op[id_pkg::alu_sll] = inst_sll_w | inst_slli_w;
	assign alu_op[id_pkg::alu_srl] = inst_srl_w | inst_srli_w;
	assign alu_op[id_pkg::alu_sra] = inst_sra_w | inst_srai_w;
	assign alu_op[id_pkg::alu_lui] = inst_lu12i_w;

	assign cond_br = inst_beq | inst_bne | inst_blt | inst_bge | inst_bltu | inst_bgeu;
	assign need_ui12 = inst_andi | inst_ori | inst_xori;
	assign need_si20 = inst_lu12i_w | inst_pcaddu12i;
	assign need_si26 = inst_b | inst_bl;

	assign src1_is_pc = inst_jirl | inst_bl | inst_pcaddu12i; // link value is pc + 4.
	assign src2_is_imm = inst_slli_w | inst_srli_w | inst_srai_w | inst_addi_w
		| inst_slti | inst_sltui | need_ui12 | need_si20 | inst_ld_w | inst_st_w
		| inst_jirl | inst_bl;
	assign res_from_mem = inst_ld_w;
	assign mem_we = inst_st_w;
	assign gr_we = (|alu_op) & ~inst_st_w; // unknown words leave alu_op at zero.
	assign dest = inst_bl ? id_pkg::reg_ra : rd;
	assign raddr1 = rj;
	assign raddr2 = (inst_st_w | cond_br) ? rd : rk;

	always_comb begin
		if (inst_jirl | inst_bl)
			imm = 32'd4;
		else if (need_si20)
			imm = {i20, 12'b0};
		else if (need_ui12)
			imm = {20'b0, i12};
		else
			imm = {{20{i12[11]}}, i12};
	end

	assign br_offs = need_si26 ? {{4{i26[25]}}, i26, 2'b0} : {{14{i16[15]}}, i16, 2'b0};

	always_comb begin
		br_kind = id_pkg::br_none;
		if (inst_beq) br_kind = id_pkg::br_eq;
		if (inst_bne) br_kind = id_pkg::br_ne;
		if (inst_blt) br_kind = id_pkg::br_lt;
		if (inst_bge) br_kind = id_pkg::br_ge;
		if (inst_bltu) br_kind = id_pkg::br_ltu;
		if (inst_bgeu) br_kind = id_pkg::br_geu;
		if (need_si26) br_kind = id_pkg::br_always;
		if (inst_jirl) br_kind = id_pkg::br_jirl;
	end

endmodule

`default_nettype wire

//--- logic/regfile.sv
`default_nettype none

module regfile (
	input wire clk,
	input wire [id_pkg::reg_addr_w-1:0] raddr1,
	output logic [id_pkg::xlen-1:0] rdata1,
	input wire [id_pkg::reg_addr_w-1:0] raddr2,
	output logic [id_pkg::xlen-1:0] rdata2,
	input wire we,
	input wire [id_pkg::reg_addr_w-1:0] waddr,
	input wire [id_pkg::xlen-1:0] wdata
);

	logic [id_pkg::xlen-1:0] regs [2**id_pkg::reg_addr_w];

	always_ff @(posedge clk) begin
		if (we && waddr != '0)
			regs[waddr] <= wdata; // r0 is hardwired.
	end

	// reads are combinational, same-cycle writes come in through the bypass.
	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

//--- logic/operand_bypass.sv
`default_nettype none

module operand_bypass (
	input wire [id_pkg::reg_addr_w-1:0] raddr,
	input wire [id_pkg::xlen-1:0] rf_data,
	input wire exe_valid,
	input wire exe_gr_we,
	input wire [id_pkg::reg_addr_w-1:0] exe_dest,
	input wire [id_pkg::xlen-1:0] exe_result,
	input wire exe_is_load,
	input wire mem_valid,
	input wire mem_gr_we,
	input wire [id_pkg::reg_addr_w-1:0] mem_dest,
	input wire [id_pkg::xlen-1:0] mem_result,
	input wire wb_we,
	input wire [id_pkg::reg_addr_w-1:0] wb_dest,
	input wire [id_pkg::xlen-1:0] wb_data,
	output logic [id_pkg::xlen-1:0] value,
	output logic load_hazard
);

	logic nonzero;
	logic exe_hit;
	logic mem_hit;
	logic wb_hit;

	////////////////////////////////////////////////////////////////////////////
	// source matches.
	assign nonzero = raddr != '0;

	assign exe_hit = nonzero & exe_valid & exe_gr_we & (exe_dest == raddr);
	assign mem_hit = nonzero & mem_valid & mem_gr_we & (mem_dest == raddr);
	assign wb_hit = nonzero & wb_we & (wb_dest == raddr);

	// a load in exe has no data yet.
	assign load_hazard = exe_hit & exe_is_load;

	// youngest producer wins.
	always_comb begin
		if (!nonzero)
			value = '0;
		else if (exe_hit)
			value = exe_result;
		else if (mem_hit)
			value = mem_result;
		else if (wb_hit)
			value = wb_data;
		else
			value = rf_data;
	end

endmodule

`default_nettype wire

//--- logic/branch_unit.sv
`default_nettype none

module branch_unit (
	input wire valid,
	input wire [id_pkg::br_kind_w-1:0] br_kind,
	input wire [id_pkg::xlen-1:0] br_offs,
	input wire [id_pkg::xlen-1:0] pc,
	input wire [id_pkg::xlen-1:0] rj_value,
	input wire [id_pkg::xlen-1:0] rkd_value,
	output logic br_taken,
	output logic [id_pkg::xlen-1:0] br_target
);

	logic eq;
	logic lt;
	logic ltu;
	logic cond;

	assign eq = rj_value == rkd_value;
	assign lt = $signed(rj_value) < $signed(rkd_value);
	assign ltu = rj_value < rkd_value;

	always_comb begin
		case (br_kind)
			id_pkg::br_eq: cond = eq;
			id_pkg::br_ne: cond = !eq;
			id_pkg::br_lt: cond = lt;
			id_pkg::br_ge: cond = !lt;
			id_pkg::br_ltu: cond = ltu;
			id_pkg::br_geu: cond = !ltu;
			id_pkg::br_always,
			id_pkg::br_jirl: cond = 1'b1;
			default: cond = 1'b0;
		endcase
	end

	assign br_taken = valid & cond;

	// jirl is register relative, everything else pc relative.
	assign br_target = ((br_kind == id_pkg::br_jirl) ? rj_value : pc) + br_offs;

endmodule

`default_nettype wire

//--- logic/id_stage.sv
`default_nettype none

module id_stage (
	input wire clk,
	input wire reset,
	input wire flush,
	// fetch.
	input wire if_valid,
	input wire id_pkg::inst_u if_inst,
	input wire [id_pkg::xlen-1:0] if_pc,
	output logic id_allowin,
	// exe.
	input wire exe_allowin,
	output logic id_to_exe_valid,
	output logic [id_pkg::alu_op_w-1:0] alu_op,
	output logic src1_is_pc,
	output logic src2_is_imm,
	output logic res_from_mem,
	output logic gr_we,
	output logic mem_we,
	output logic [id_pkg::reg_addr_w-1:0] dest,
	output logic [id_pkg::xlen-1:0] id_pc,
	output logic [id_pkg::xlen-1:0] rj_value,
	output logic [id_pkg::xlen-1:0] rkd_value,
	output logic [id_pkg::xlen-1:0] imm,
	// branch.
	output logic br_taken,
	output logic [id_pkg::xlen-1:0] br_target,
	output logic br_stall,
	// forwarding.
	input wire exe_valid,
	input wire exe_gr_we,
	input wire [id_pkg::reg_addr_w-1:0] exe_dest,
	input wire [id_pkg::xlen-1:0] exe_result,
	input wire exe_is_load,
	input wire mem_valid,
	input wire mem_gr_we,
	input wire [id_pkg::reg_addr_w-1:0] mem_dest,
	input wire [id_pkg::xlen-1:0] mem_result,
	input wire wb_we,
	input wire [id_pkg::reg_addr_w-1:0] wb_dest,
	input wire [id_pkg::xlen-1:0] wb_data
);

	logic id_valid;
	logic ready_go;
	id_pkg::inst_u inst_r;
	logic [id_pkg::xlen-1:0] pc_r;
	logic [id_pkg::reg_addr_w-1:0] raddr1, raddr2;
	logic [id_pkg::xlen-1:0] rdata1, rdata2;
	logic rj_hazard, rkd_hazard;
	logic [id_pkg::br_kind_w-1:0] br_kind;
	logic [id_pkg::xlen-1:0] br_offs;

	////////////////////////////////////////////////////////////////////////////
	// stage control.
	assign ready_go = ~(rj_hazard | rkd_hazard);
	assign id_allowin = ~id_valid | (ready_go & exe_allowin);
	assign id_to_exe_valid = id_valid & ready_go;
	assign br_stall = id_valid & ~ready_go;

	always_ff @(posedge clk) begin
		if (reset || flush)
			id_valid <= 1'b0;
		else if (id_allowin)
			id_valid <= if_valid & ~br_taken; // fetch word behind a taken branch is dropped.
	end

	always_ff @(posedge clk) begin
		if (if_valid && id_allowin) begin
			inst_r <= if_inst;
			pc_r <= if_pc;
		end
	end

	assign id_pc = pc_r;

	////////////////////////////////////////////////////////////////////////////
	// datapath.
	inst_decoder u_decoder (
		.inst(inst_r),
		.alu_op(alu_op),
		.src1_is_pc(src1_is_pc),
		.src2_is_imm(src2_is_imm),
		.res_from_mem(res_from_mem),
		.gr_we(gr_we),
		.mem_we(mem_we),
		.dest(dest),
		.imm(imm),
		.raddr1(raddr1),
		.raddr2(raddr2),
		.br_kind(br_kind),
		.br_offs(br_offs)
	);

	regfile u_regfile (
		.clk(clk),
		.raddr1(raddr1),
		.rdata1(rdata1),
		.raddr2(raddr2),
		.rdata2(rdata2),
		.we(wb_we),
		.waddr(wb_dest),
		.wdata(wb_data)
	);

	operand_bypass u_bypass_rj (
		.raddr(raddr1), .rf_data(rdata1),
		.exe_valid(exe_valid), .exe_gr_we(exe_gr_we), .exe_dest(exe_dest),
		.exe_result(exe_result), .exe_is_load(exe_is_load),
		.mem_valid(mem_valid), .mem_gr_we(mem_gr_we), .mem_dest(mem_dest),
		.mem_result(mem_result),
		.wb_we(wb_we), .wb_dest(wb_dest), .wb_data(wb_data),
		.value(rj_value), .load_hazard(rj_hazard)
	);

	operand_bypass u_bypass_rkd (
		.raddr(raddr2), .rf_data(rdata2),
		.exe_valid(exe_valid), .exe_gr_we(exe_gr_we), .exe_dest(exe_dest),
		.exe_result(exe_result), .exe_is_load(exe_is_load),
		.mem_valid(mem_valid), .mem_gr_we(mem_gr_we), .mem_dest(mem_dest),
		.mem_result(mem_result),
		.wb_we(wb_we), .wb_dest(wb_dest), .wb_data(wb_data),
		.value(rkd_value), .load_hazard(rkd_hazard)
	);

	branch_unit u_branch (
		.valid(id_valid),
		.br_kind(br_kind),
		.br_offs(br_offs),
		.pc(pc_r),
		.rj_value(rj_value),
		.rkd_value(rkd_value),
		.br_taken(br_taken),
		.br_target(br_target)
	);

endmodule

`default_nettype wire

//--- tb/id_stage_properties.sv
`default_nettype none

module id_stage_properties (
	input wire clk,
	input wire reset,
	input wire id_to_exe_valid,
	input wire br_taken,
	input wire br_stall
);

	// nothing leaves the stage during reset and the cycle after.
	reset_quiet: assert property (@(posedge clk) reset |=> !id_to_exe_valid && !br_taken)
		else $error("stage active during or right after reset");

	stall_excl: assert property (@(posedge clk) disable iff (reset)
		!(br_stall && id_to_exe_valid))
		else $error("br_stall and id_to_exe_valid high together");

	taken_needs_item: assert property (@(posedge clk) disable iff (reset)
		br_taken |-> (id_to_exe_valid || br_stall))
		else $error("br_taken without an instruction in the stage");

endmodule

bind id_stage id_stage_properties i_props (
	.clk(clk),
	.reset(reset),
	.id_to_exe_valid(id_to_exe_valid),
	.br_taken(br_taken),
	.br_stall(br_stall)
);

`default_nettype wire

//--- tb/tb_id_stage.sv
`default_nettype none

module tb_id_stage;

	typedef struct packed {
		logic ev;
		logic [4:0] ed;
		logic [31:0] er;
		logic el;
		logic mv;
		logic [4:0] md;
		logic [31:0] mr;
		logic wv;
		logic [4:0] wd;
		logic [31:0] wdat;
	} fwd_t;

	typedef struct packed {
		logic [31:0] inst;
		logic [31:0] pc;
		fwd_t fw;
		logic allow;
		logic [11:0] x_alu;
		logic [31:0] x_imm;
		logic [4:0] x_dest;
		logic [31:0] x_rj;
		logic [31:0] x_rkd;
		logic [4:0] x_ctl; // {src1_is_pc, src2_is_imm, res_from_mem, gr_we, mem_we}.
		logic x_br;
		logic x_taken;
		logic [31:0] x_target;
	} row_t;

	logic clk, reset, flush, if_valid, id_allowin, exe_allowin, id_to_exe_valid;
	logic [31:0] if_inst, if_pc, id_pc, rj_value, rkd_value, imm, br_target;
	logic [11:0] alu_op;
	logic src1_is_pc, src2_is_imm, res_from_mem, gr_we, mem_we, br_taken, br_stall;
	logic [4:0] dest, exe_dest, mem_dest, wb_dest;
	logic exe_valid, exe_gr_we, exe_is_load, mem_valid, mem_gr_we, wb_we;
	logic [31:0] exe_result, mem_result, wb_data;

	logic [31:0] model [32];
	row_t rows[$];
	fwd_t fw;
	logic allow_next;
	logic [31:0] pc_next;
	int value_errors;
	int timeout_errors;

	id_stage i_dut (
		.clk(clk), .reset(reset), .flush(flush),
		.if_valid(if_valid), .if_inst(if_inst), .if_pc(if_pc), .id_allowin(id_allowin),
		.exe_allowin(exe_allowin), .id_to_exe_valid(id_to_exe_valid), .alu_op(alu_op),
		.src1_is_pc(src1_is_pc), .src2_is_imm(src2_is_imm), .res_from_mem(res_from_mem),
		.gr_we(gr_we), .mem_we(mem_we), .dest(dest), .id_pc(id_pc),
		.rj_value(rj_value), .rkd_value(rkd_value), .imm(imm),
		.br_taken(br_taken), .br_target(br_target), .br_stall(br_stall),
		.exe_valid(exe_valid), .exe_gr_we(exe_gr_we), .exe_dest(exe_dest),
		.exe_result(exe_result), .exe_is_load(exe_is_load),
		.mem_valid(mem_valid), .mem_gr_we(mem_gr_we), .mem_dest(mem_dest),
		.mem_result(mem_result), .wb_we(wb_we), .wb_dest(wb_dest), .wb_data(wb_data)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// instruction words and expected values.
	function automatic logic [31:0] enc_3r(input logic [16:0] op, input logic [4:0] rk,
		input logic [4:0] rj, input logic [4:0] rd);
		return {op, rk, rj, rd};
	endfunction

	function automatic logic [31:0] enc_2ri12(input logic [9:0] op, input logic [11:0] i12,
		input logic [4:0] rj, input logic [4:0] rd);
		return {op, i12, rj, rd};
	endfunction

	function automatic logic [31:0] enc_2ri16(input logic [5:0] op, input logic [15:0] o,
		input logic [4:0] rj, input logic [4:0] rd);
		return {op, o, rj, rd};
	endfunction

	function automatic logic [31:0] enc_i26(input logic [5:0] op, input logic [25:0] o);
		return {op, o[15:0], o[25:16]}; // high offset bits go low.
	endfunction

	function automatic logic [31:0] sext12(input logic [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	function automatic logic [31:0] offs16(input logic [15:0] o);
		return {{14{o[15]}}, o, 2'b00};
	endfunction

	function automatic logic [31:0] offs26(input logic [25:0] o);
		return {{4{o[25]}}, o, 2'b00};
	endfunction

	function automatic logic [11:0] one_hot(input int b);
		logic [11:0] v;
		v = '0;
		v[b] = 1'b1;
		return v;
	endfunction

	// a matching load in exe is gone once the stall clears.
	function automatic logic [31:0] source_value(input logic [4:0] r);
		if (r == 5'd0)
			return 32'd0;
		if (fw.ev && fw.ed == r && !fw.el)
			return fw.er;
		if (fw.mv && fw.md == r)
			return fw.mr;
		if (fw.wv && fw.wd == r)
			return fw.wdat;
		return model[r];
	endfunction

	task automatic add_row(input logic [31:0] w, input logic [11:0] alu,
		input logic [31:0] x_imm, input logic [4:0] x_dest, input logic [4:0] rkd_reg,
		input logic [4:0] ctl, input logic is_br, input logic taken, input logic [31:0] tgt);
		row_t r;
		r.inst = w;
		r.pc = pc_next;
		r.fw = fw;
		r.allow = allow_next;
		r.x_alu = alu;
		r.x_imm = x_imm;
		r.x_dest = x_dest;
		r.x_rj = source_value(w[9:5]);
		r.x_rkd = source_value(rkd_reg);
		r.x_ctl = ctl;
		r.x_br = is_br;
		r.x_taken = taken;
		r.x_target = tgt;
		rows.push_back(r);
		pc_next = pc_next + 32'd4;
		// later rows see the wb write.
		if (fw.wv && fw.wd != 5'd0)
			model[fw.wd] = fw.wdat;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// drive and check.
	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("Fail t=%0t %s expected %h got %h", $time, name, exp, got);
			value_errors++;
		end
	endtask

	task automatic apply_fwd(input fwd_t f);
		exe_valid = f.ev;
		exe_gr_we = f.ev;
		exe_dest = f.ed;
		exe_result = f.er;
		exe_is_load = f.el;
		mem_valid = f.mv;
		mem_gr_we = f.mv;
		mem_dest = f.md;
		mem_result = f.mr;
		wb_we = f.wv;
		wb_dest = f.wd;
		wb_data = f.wdat;
	endtask

	task automatic check_outputs(input row_t r);
		check("alu_op", 32'(alu_op), 32'(r.x_alu));
		check("imm", imm, r.x_imm);
		check("dest", 32'(dest), 32'(r.x_dest));
		check("rj_value", rj_value, r.x_rj);
		check("rkd_value", rkd_value, r.x_rkd);
		check("src1_is_pc", 32'(src1_is_pc), 32'(r.x_ctl[4]));
		check("src2_is_imm", 32'(src2_is_imm), 32'(r.x_ctl[3]));
		check("res_from_mem", 32'(res_from_mem), 32'(r.x_ctl[2]));
		check("gr_we", 32'(gr_we), 32'(r.x_ctl[1]));
		check("mem_we", 32'(mem_we), 32'(r.x_ctl[0]));
		check("id_pc", id_pc, r.pc);
		check("br_taken", 32'(br_taken), 32'(r.x_taken));
		if (r.x_br)
			check("br_target", br_target, r.x_target);
	endtask

	task automatic run_row(input row_t r);
		int cnt;
		check("id_allowin", 32'(id_allowin), 32'd1);
		if_valid = 1'b1;
		if_inst = r.inst;
		if_pc = r.pc;
		exe_allowin = r.allow;
		step();
		// wb data is not in the file yet, only the bypass has it.
		apply_fwd(r.fw);
		// a wrong-path word follows each taken branch.
		if_valid = r.x_taken;
		if_inst = enc_3r(id_pkg::op3r_add_w, 5'd1, 5'd1, 5'd1);
		#1;
		if (r.fw.el) begin
			check("id_to_exe_valid", 32'(id_to_exe_valid), 32'd0);
			check("id_allowin", 32'(id_allowin), 32'd0);
			check("br_stall", 32'(br_stall), 32'd1);
			step();
			exe_valid = 1'b0; // load leaves exe.
			#1;
		end
		cnt = 0;
		while (!id_to_exe_valid && cnt < 10) begin
			step();
			#1;
			cnt++;
		end
		assert (id_to_exe_valid) else begin
			$display("timeout waiting for id_to_exe_valid at t=%0t", $time);
			timeout_errors++;
		end
		check_outputs(r);
		if (!r.allow) begin
			if_valid = 1'b1; // fetch keeps offering a word.
			repeat (3) begin
				step();
				#1;
				check("id_to_exe_valid", 32'(id_to_exe_valid), 32'd1);
				check("id_allowin", 32'(id_allowin), 32'd0);
				check_outputs(r);
			end
			step();
			if_valid = 1'b0;
			exe_allowin = 1'b1;
		end
		step();
		if_valid = 1'b0;
		#1;
		check("id_to_exe_valid", 32'(id_to_exe_valid), 32'd0);
		step();
		apply_fwd('0);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// main sequence.
	initial begin
		int unsigned seed;
		logic [31:0] w;
		logic [11:0] add;
		seed = $urandom(80);
		reset = 1'b1;
		flush = 1'b0;
		if_valid = 1'b0;
		if_inst = '0;
		if_pc = '0;
		exe_allowin = 1'b1;
		apply_fwd('0);
		value_errors = 0;
		timeout_errors = 0;
		fw = '0;
		allow_next = 1'b1;
		pc_next = 32'h1c00_0100;
		add = one_hot(id_pkg::alu_add);
		repeat (16) @(posedge clk);
		#1;
		reset = 1'b0;
		#1;
		check("id_to_exe_valid", 32'(id_to_exe_valid), 32'd0);
		check("br_taken", 32'(br_taken), 32'd0);
		check("br_stall", 32'(br_stall), 32'd0);
		check("id_allowin", 32'(id_allowin), 32'd1);

		// preload through the wb port.
		model[0] = 32'd0;
		for (int i = 1; i < 32; i++) begin
			step();
			wb_we = 1'b1;
			wb_dest = 5'(i);
			wb_data = $urandom;
			model[i] = wb_data;
		end
		step();
		wb_we = 1'b0;

		w = enc_3r(id_pkg::op3r_add_w, 5'd4, 5'd3, 5'd5);
		add_row(w, add, sext12(w[21:10]), 5'd5, 5'd4, 5'b00010, 1'b0, 1'b0, '0);
		w = enc_3r(id_pkg::op3r_sub_w, 5'd0, 5'd7, 5'd6);
		add_row(w, one_hot(id_pkg::alu_sub), sext12(w[21:10]), 5'd6, 5'd0, 5'b00010,
			1'b0, 1'b0, '0);
		w = enc_3r(id_pkg::op3r_slt, 5'd9, 5'd0, 5'd8);
		add_row(w, one_hot(id_pkg::alu_slt), sext12(w[21:10]), 5'd8, 5'd9, 5'b00010,
			1'b0, 1'b0, '0);
		w = enc_3r(id_pkg::op3r_sltu, 5'd11, 5'd10, 5'd9);
		add_row(w, one_hot(id_pkg::alu_sltu), sext12(w[21:10]), 5'd9, 5'd11, 5'b00010,
			1'b0, 1'b0, '0);
		w = enc_3r(id_pkg::op3r_nor, 5'd3, 5'd2, 5'd1);
		add_row(w, one_hot(id_pkg::alu_nor), sext12(w[21:10]), 5'd1, 5'd3, 5'b00010,
			1'b0, 1'b0, '0);
		w = enc_3r(id_pkg::op3r_and, 5'd19, 5'd18, 5'd4);
		add_row(w, one_hot(id_pkg::alu_and), sext12(w[21:10]), 5'd4, 5'd19, 5'b00010,
			1'b0, 1'b0, '0);
		w = enc_3r(id_pkg::op3r_xor, 5'd13, 5'd12, 5'd2);
		add_row(w, one_hot(id_pkg::alu_xor), sext12(w[21:10]), 5'd2, 5'd13, 5'b00010,
			1'b0, 1'b0, '0);
		w = enc_3r(id_pkg::op3r_sll_w, 5'd21, 5'd20, 5'd5);
		add_row(w, one_hot(id_pkg::alu_sll), sext12(w[21:10]), 5'd5, 5'd21, 5'b00010,
			1'b0, 1'b0, '0);
		w = enc_3r(id_pkg::op3r_srl_w, 5'd23, 5'd22, 5'd6);
		add_row(w, one_hot(id_pkg::alu_srl), sext12(w[21:10]), 5'd6, 5'd23, 5'b00010,
			1'b0, 1'b0, '0);
		w = enc_3r(id_pkg::op3r_sra_w, 5'd15, 5'd14, 5'd3);
		add_row(w, one_hot(id_pkg::alu_sra), sext12(w[21:10]), 5'd3, 5'd15, 5'b00010,
			1'b0, 1'b0, '0);
		w = enc_3r(id_pkg::op3r_slli_w, 5'd7, 5'd11, 5'd10);
		add_row(w, one_hot(id_pkg::alu_sll), sext12(w[21:10]), 5'd10, 5'd7, 5'b01010,
			1'b0, 1'b0, '0);
		w = enc_3r(id_pkg::op3r_srli_w, 5'd9, 5'd25, 5'd7);
		add_row(w, one_hot(id_pkg::alu_srl), sext12(w[21:10]), 5'd7, 5'd9, 5'b01010,
			1'b0, 1'b0, '0);
		w = enc_3r(id_pkg::op3r_srai_w, 5'd31, 5'd27, 5'd8);
		add_row(w, one_hot(id_pkg::alu_sra), sext12(w[21:10]), 5'd8, 5'd31, 5'b01010,
			1'b0, 1'b0, '0);
		w = enc_2ri12(id_pkg::op12_addi_w, 12'hffb, 5'd13, 5'd12);
		add_row(w, add, 32'hffff_fffb, 5'd12, w[14:10], 5'b01010, 1'b0, 1'b0, '0);
		w = enc_2ri12(id_pkg::op12_slti, 12'h7ff, 5'd29, 5'd9);
		add_row(w, one_hot(id_pkg::alu_slt), 32'h0000_07ff, 5'd9, w[14:10], 5'b01010,
			1'b0, 1'b0, '0);
		w = enc_2ri12(id_pkg::op12_sltui, 12'h801, 5'd30, 5'd10);
		add_row(w, one_hot(id_pkg::alu_sltu), 32'hffff_f801, 5'd10, w[14:10], 5'b01010,
			1'b0, 1'b0, '0);
		w = enc_2ri12(id_pkg::op12_andi, 12'hf0f, 5'd15, 5'd14);
		add_row(w, one_hot(id_pkg::alu_and), 32'h0000_0f0f, 5'd14, w[14:10], 5'b01010,
			1'b0, 1'b0, '0);
		w = enc_2ri12(id_pkg::op12_ori, 12'h800, 5'd17, 5'd16);
		add_row(w, one_hot(id_pkg::alu_or), 32'h0000_0800, 5'd16, w[14:10], 5'b01010,
			1'b0, 1'b0, '0);
		w = enc_2ri12(id_pkg::op12_xori, 12'hfff, 5'd31, 5'd11);
		add_row(w, one_hot(id_pkg::alu_xor), 32'h0000_0fff, 5'd11, w[14:10], 5'b01010,
			1'b0, 1'b0, '0);
		w = {id_pkg::op20_lu12i_w, 20'h80001, 5'd16};
		add_row(w, one_hot(id_pkg::alu_lui), 32'h8000_1000, 5'd16, w[14:10], 5'b01010,
			1'b0, 1'b0, '0);
		w = {id_pkg::op20_pcaddu12i, 20'h00003, 5'd17};
		add_row(w, add, 32'h0000_3000, 5'd17, w[14:10], 5'b11010, 1'b0, 1'b0, '0);
		w = enc_2ri12(id_pkg::op12_ld_w, 12'h008, 5'd18, 5'd17);
		add_row(w, add, 32'd8, 5'd17, w[14:10], 5'b01110, 1'b0, 1'b0, '0);
		w = enc_2ri12(id_pkg::op12_st_w, 12'hffc, 5'd20, 5'd19);
		add_row(w, add, 32'hffff_fffc, 5'd19, 5'd19, 5'b01001, 1'b0, 1'b0, '0);

		// forwarding priority, exe then mem then wb.
		w = enc_3r(id_pkg::op3r_add_w, 5'd0, 5'd22, 5'd21);
		fw = {1'b1, 5'd22, 32'h1111_1111, 1'b0, 1'b1, 5'd22, 32'h2222_2222,
			1'b1, 5'd22, 32'h3333_3333};
		add_row(w, add, sext12(w[21:10]), 5'd21, 5'd0, 5'b00010, 1'b0, 1'b0, '0);
		fw.ev = 1'b0;
		add_row(w, add, sext12(w[21:10]), 5'd21, 5'd0, 5'b00010, 1'b0, 1'b0, '0);
		fw.mv = 1'b0;
		fw.wdat = 32'h4444_4444;
		add_row(w, add, sext12(w[21:10]), 5'd21, 5'd0, 5'b00010, 1'b0, 1'b0, '0);
		w = enc_3r(id_pkg::op3r_add_w, 5'd4, 5'd0, 5'd21);
		fw = {1'b1, 5'd0, 32'h5555_5555, 1'b0, 1'b1, 5'd0, 32'h6666_6666,
			1'b1, 5'd0, 32'h7777_7777};
		add_row(w, add, sext12(w[21:10]), 5'd21, 5'd4, 5'b00010, 1'b0, 1'b0, '0);

		// load-use stalls.
		w = enc_3r(id_pkg::op3r_add_w, 5'd25, 5'd24, 5'd23);
		fw = '0;
		fw.ev = 1'b1;
		fw.ed = 5'd24;
		fw.er = 32'hdead_0001;
		fw.el = 1'b1;
		fw.mv = 1'b1;
		fw.md = 5'd24;
		fw.mr = 32'h0bad_0002;
		add_row(w, add, sext12(w[21:10]), 5'd23, 5'd25, 5'b00010, 1'b0, 1'b0, '0);
		fw.mv = 1'b0;
		fw.ed = 5'd26;
		w = enc_2ri16(id_pkg::op16_beq, 16'h0010, 5'd26, 5'd26);
		add_row(w, '0, sext12(w[21:10]), 5'd26, 5'd26, 5'b00000, 1'b1, 1'b1,
			pc_next + offs16(16'h0010));
		fw = '0;

		// branches.
		w = enc_2ri16(id_pkg::op16_beq, 16'h0010, 5'd1, 5'd2);
		add_row(w, '0, sext12(w[21:10]), 5'd2, 5'd2, 5'b00000, 1'b1,
			model[1] == model[2], pc_next + offs16(16'h0010));
		w = enc_2ri16(id_pkg::op16_bne, 16'hfff0, 5'd1, 5'd2);
		add_row(w, '0, sext12(w[21:10]), 5'd2, 5'd2, 5'b00000, 1'b1,
			model[1] != model[2], pc_next + offs16(16'hfff0));
		w = enc_2ri16(id_pkg::op16_blt, 16'h0020, 5'd4, 5'd5);
		add_row(w, '0, sext12(w[21:10]), 5'd5, 5'd5, 5'b00000, 1'b1,
			$signed(model[4]) < $signed(model[5]), pc_next + offs16(16'h0020));
		w = enc_2ri16(id_pkg::op16_bge, 16'h0020, 5'd4, 5'd5);
		add_row(w, '0, sext12(w[21:10]), 5'd5, 5'd5, 5'b00000, 1'b1,
			$signed(model[4]) >= $signed(model[5]), pc_next + offs16(16'h0020));
		w = enc_2ri16(id_pkg::op16_bltu, 16'h8000, 5'd6, 5'd7);
		add_row(w, '0, sext12(w[21:10]), 5'd7, 5'd7, 5'b00000, 1'b1,
			model[6] < model[7], pc_next + offs16(16'h8000));
		w = enc_2ri16(id_pkg::op16_bgeu, 16'h0004, 5'd6, 5'd7);
		add_row(w, '0, sext12(w[21:10]), 5'd7, 5'd7, 5'b00000, 1'b1,
			model[6] >= model[7], pc_next + offs16(16'h0004));
		w = enc_2ri16(id_pkg::op16_jirl, 16'h0003, 5'd4, 5'd1);
		add_row(w, add, 32'd4, 5'd1, w[14:10], 5'b11010, 1'b1, 1'b1,
			model[4] + offs16(16'h0003));
		w = enc_i26(id_pkg::op26_b, 26'h3ff_ff00);
		add_row(w, '0, sext12(w[21:10]), w[4:0], w[14:10], 5'b00000, 1'b1, 1'b1,
			pc_next + offs26(26'h3ff_ff00));
		w = enc_i26(id_pkg::op26_bl, 26'h000_0040);
		add_row(w, add, 32'd4, id_pkg::reg_ra, w[14:10], 5'b11010, 1'b1, 1'b1,
			pc_next + offs26(26'h000_0040));

		// back-pressure.
		allow_next = 1'b0;
		w = enc_3r(id_pkg::op3r_or, 5'd28, 5'd27, 5'd26);
		add_row(w, one_hot(id_pkg::alu_or), sext12(w[21:10]), 5'd26, 5'd28, 5'b00010,
			1'b0, 1'b0, '0);

		foreach (rows[i])
			run_row(rows[i]);

		// flush drops a held instruction.
		if_valid = 1'b1;
		if_inst = enc_3r(id_pkg::op3r_and, 5'd2, 5'd3, 5'd4);
		exe_allowin = 1'b0;
		step();
		if_valid = 1'b0;
		#1;
		check("id_to_exe_valid", 32'(id_to_exe_valid), 32'd1);
		step();
		flush = 1'b1;
		step();
		flush = 1'b0;
		exe_allowin = 1'b1;
		#1;
		check("id_to_exe_valid", 32'(id_to_exe_valid), 32'd0);

		step();
		$display("errors: %0d value, %0d timeout", value_errors, timeout_errors);
		if (value_errors == 0 && timeout_errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
logic/id_pkg.sv
logic/inst_decoder.sv
logic/regfile.sv
logic/operand_bypass.sv
logic/branch_unit.sv
logic/id_stage.sv
tb/id_stage_properties.sv
tb/tb_id_stage.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the ID stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
	-f files.f \
	--top-module tb_id_stage \
	-Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
	echo "build failed with status $status"
	exit 1
fi

./obj_dir/Vtb_id_stage > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^PASS: all tests$" sim.log; then
	exit 0
fi
exit 1
